//--- filelist.f
mips_pkg.sv
de_bus_if.sv
instr_decoder.sv
de_pipe_reg.sv
exec_stage.sv
mips_de_ex_top.sv
tb_mips_de_ex.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the D/E slice testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f filelist.f --top-module tb_mips_de_ex --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
    exit 0
fi
exit 1

//--- tb_mips_de_ex.sv
`timescale 1ns/1ns

module tb_mips_de_ex import mips_pkg::*; ();

    localparam int    RESET_CYCLES   = 4;
    localparam int    N_RANDOM       = 156;
    localparam int    N_DIRECTED     = 40;    // Upper bound on directed and drain steps
    localparam int    TIMEOUT_CYCLES = 2 * (RESET_CYCLES + N_RANDOM + N_DIRECTED);
    localparam word_t EXPECT_RESET_PC = 32'h0000_3000;
    localparam word_t EXPECT_EXC_PC   = 32'h0000_4180;
    localparam word_t ERET_WORD       = 32'h4200_0018;
    localparam word_t NOP             = 32'h0000_0000;
    localparam word_t REGS_123        = 32'h0022_1800;    // rs 1, rt 2, rd 3

    typedef struct packed {
        logic      rfwe;
        logic      exc;
        logic      is_eret;
        word_t     result;
        reg_addr_t wreg;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     pc;
        tnew_t     tnew;
    } exp_t;

    logic      clk;
    logic      reset;
    logic      clear;
    word_t     instr;
    word_t     pc;
    word_t     rs_data;
    word_t     rt_data;
    word_t     epc;
    word_t     result_m;
    word_t     pc_m;
    word_t     pc_e;
    reg_addr_t wreg_m;
    reg_addr_t rs_e;
    reg_addr_t rt_e;
    logic      rfwe_m;
    logic      exc;
    tnew_t     tnew_e;

    exp_t      exp_q[$];    // Oldest entry is in M, the next one in E
    logic      hold_reset;
    logic      chk_en;
    logic      exp_m_rfwe;
    word_t     exp_m_result;
    reg_addr_t exp_m_wreg;
    word_t     exp_m_pc;
    word_t     exp_e_pc;
    reg_addr_t exp_e_rs;
    reg_addr_t exp_e_rt;
    tnew_t     exp_e_tnew;
    logic      exp_e_exc;
    word_t     seed;
    word_t     fetch_pc;
    int        errors;
    int        errs_at_start;
    int        test_num;
    int        tests_passed;
    int        tests_failed;
    int        cycles;

    mips_de_ex_top DUT (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .instr    (instr),
        .pc       (pc),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .epc      (epc),
        .result_m (result_m),
        .pc_m     (pc_m),
        .pc_e     (pc_e),
        .wreg_m   (wreg_m),
        .rs_e     (rs_e),
        .rt_e     (rt_e),
        .rfwe_m   (rfwe_m),
        .exc      (exc),
        .tnew_e   (tnew_e)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    a_rfwe_m: assert property (@(posedge clk) !chk_en || rfwe_m == exp_m_rfwe)
        else begin
            errors++;
            $display("Mismatch rfwe_m: got %h, expected %h", rfwe_m, exp_m_rfwe);
        end

    a_result_m: assert property (@(posedge clk) !chk_en || !exp_m_rfwe || result_m == exp_m_result)
        else begin
            errors++;
            $display("Mismatch result_m: got %h, expected %h", result_m, exp_m_result);
        end

    a_wreg_m: assert property (@(posedge clk) !chk_en || !exp_m_rfwe || wreg_m == exp_m_wreg)
        else begin
            errors++;
            $display("Mismatch wreg_m: got %h, expected %h", wreg_m, exp_m_wreg);
        end

    a_pc_m: assert property (@(posedge clk) !chk_en || pc_m == exp_m_pc)
        else begin
            errors++;
            $display("Mismatch pc_m: got %h, expected %h", pc_m, exp_m_pc);
        end

    a_pc_e: assert property (@(posedge clk) !chk_en || pc_e == exp_e_pc)
        else begin
            errors++;
            $display("Mismatch pc_e: got %h, expected %h", pc_e, exp_e_pc);
        end

    a_rs_e: assert property (@(posedge clk) !chk_en || rs_e == exp_e_rs)
        else begin
            errors++;
            $display("Mismatch rs_e: got %h, expected %h", rs_e, exp_e_rs);
        end

    a_rt_e: assert property (@(posedge clk) !chk_en || rt_e == exp_e_rt)
        else begin
            errors++;
            $display("Mismatch rt_e: got %h, expected %h", rt_e, exp_e_rt);
        end

    a_tnew_e: assert property (@(posedge clk) !chk_en || tnew_e == exp_e_tnew)
        else begin
            errors++;
            $display("Mismatch tnew_e: got %h, expected %h", tnew_e, exp_e_tnew);
        end

    a_exc: assert property (@(posedge clk) !chk_en || exc == exp_e_exc)
        else begin
            errors++;
            $display("Mismatch exc: got %h, expected %h", exc, exp_e_exc);
        end

    function automatic word_t next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic signed_ovf(input word_t a, input word_t b, input logic is_sub);
        logic [32:0] s;
        s = is_sub ? ({a[31], a} - {b[31], b}) : ({a[31], a} + {b[31], b});
        return s[32] ^ s[31];    // Sign bits disagree after extension
    endfunction

    function automatic word_t rtype(input logic [5:0] fn, input word_t r);
        return {OP_RTYPE, r[25:6], fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input word_t r);
        return {op, r[25:0]};
    endfunction

    function automatic exp_t bubble(input word_t p);
        exp_t e;
        e = '0;
        e.pc = p;
        return e;
    endfunction

    function automatic exp_t predict(input word_t i, input word_t p, input word_t a,
                                     input word_t b);
        exp_t  e;
        word_t se;
        word_t ze;
        tnew_t dec_tnew;
        logic  writer;
        logic  unknown;
        logic  trap;
        se       = {{16{i[15]}}, i[15:0]};
        ze       = {16'h0000, i[15:0]};
        writer   = 1'b1;
        unknown  = 1'b0;
        trap     = 1'b0;
        e        = bubble(p);
        e.rs     = i[25:21];
        e.rt     = i[20:16];
        e.wreg   = i[20:16];
        case (i[31:26])
            OP_RTYPE: begin
                e.wreg = i[15:11];
                case (i[5:0])
                    FN_ADD: begin
                        e.result = a + b;
                        trap     = signed_ovf(a, b, 1'b0);
                    end
                    FN_SUB: begin
                        e.result = a - b;
                        trap     = signed_ovf(a, b, 1'b1);
                    end
                    FN_ADDU: e.result = a + b;
                    FN_SUBU: e.result = a - b;
                    FN_AND:  e.result = a & b;
                    FN_OR:   e.result = a | b;
                    FN_XOR:  e.result = a ^ b;
                    FN_SLT:  e.result = {31'd0, ($signed(a) < $signed(b))};
                    FN_SLTU: e.result = {31'd0, (a < b)};
                    FN_SLL:  e.result = b << i[10:6];
                    FN_SRL:  e.result = b >> i[10:6];
                    default: begin
                        writer  = 1'b0;
                        unknown = 1'b1;
                    end
                endcase
            end
            OP_ADDI: begin
                e.result = a + se;
                trap     = signed_ovf(a, se, 1'b0);
            end
            OP_ADDIU: e.result = a + se;
            OP_SLTI:  e.result = {31'd0, ($signed(a) < $signed(se))};
            OP_ANDI:  e.result = a & ze;
            OP_ORI:   e.result = a | ze;
            OP_LUI:   e.result = {i[15:0], 16'h0000};
            OP_JAL: begin
                e.result = p + 32'd8;
                e.wreg   = 5'd31;
            end
            default: begin
                writer    = 1'b0;
                unknown   = (i != ERET_WORD);
                e.is_eret = (i == ERET_WORD);
            end
        endcase
        dec_tnew = writer ? 3'd1 : 3'd0;
        e.tnew   = (dec_tnew > 3'd0) ? dec_tnew - 3'd1 : 3'd0;
        e.exc    = unknown | trap;
        e.rfwe   = writer & ~e.exc;
        return e;
    endfunction

    // Drives one cycle and predicts what E will hold after the next rising edge
    task automatic step(input word_t i, input word_t p, input word_t a, input word_t b,
                        input logic clr);
        exp_t cur;
        exp_t nxt;
        @(negedge clk);
        reset   = hold_reset;
        clear   = clr;
        instr   = i;
        pc      = p;
        rs_data = a;
        rt_data = b;
        cur     = exp_q[exp_q.size() - 1];
        if (reset) begin
            nxt = bubble(EXPECT_RESET_PC);
        end else if (clr) begin
            nxt = bubble(p);
        end else if (cur.exc) begin
            nxt = bubble(EXPECT_EXC_PC);
        end else if (cur.is_eret) begin
            nxt = bubble(epc);
        end else begin
            nxt = predict(i, p, a, b);
        end
        exp_q.push_back(nxt);
        void'(exp_q.pop_front());
        exp_m_rfwe   = exp_q[0].rfwe;
        exp_m_result = exp_q[0].result;
        exp_m_wreg   = exp_q[0].wreg;
        exp_m_pc     = exp_q[0].pc;
        exp_e_pc     = exp_q[1].pc;
        exp_e_rs     = exp_q[1].rs;
        exp_e_rt     = exp_q[1].rt;
        exp_e_tnew   = exp_q[1].tnew;
        exp_e_exc    = exp_q[1].exc;
        chk_en       = chk_en | ~reset;
    endtask

    task automatic issue(input word_t i, input word_t a, input word_t b);
        step(i, fetch_pc, a, b, 1'b0);
        fetch_pc = fetch_pc + 32'd4;
    endtask

    // Three nops carry the last instruction of a test through its M check
    task automatic drain();
        repeat (3) issue(NOP, 32'd0, 32'd0);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == errs_at_start) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %0d %s: %0d errors", test_num, name, errors - errs_at_start);
        errs_at_start = errors;
    endtask

    task automatic run_random();
        word_t r;
        word_t k;
        word_t i;
        word_t a;
        word_t b;
        int    kind;
        repeat (N_RANDOM) begin
            r    = next_random();
            k    = next_random();
            a    = next_random();
            b    = next_random();
            kind = int'(k[31:16]) % 18;
            case (kind)
                0:  i = rtype(FN_ADD, r);
                1:  i = rtype(FN_ADDU, r);
                2:  i = rtype(FN_SUB, r);
                3:  i = rtype(FN_SUBU, r);
                4:  i = rtype(FN_AND, r);
                5:  i = rtype(FN_OR, r);
                6:  i = rtype(FN_XOR, r);
                7:  i = rtype(FN_SLT, r);
                8:  i = rtype(FN_SLTU, r);
                9:  i = rtype(FN_SLL, r);
                10: i = rtype(FN_SRL, r);
                11: i = itype(OP_ADDI, r);
                12: i = itype(OP_ADDIU, r);
                13: i = itype(OP_SLTI, r);
                14: i = itype(OP_ANDI, r);
                15: i = itype(OP_ORI, r);
                16: i = itype(OP_LUI, r);
                default: i = itype(OP_JAL, r);
            endcase
            issue(i, a, b);
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        clear         = 1'b0;
        instr         = '0;
        pc            = '0;
        rs_data       = '0;
        rt_data       = '0;
        epc           = '0;
        hold_reset    = 1'b1;
        chk_en        = 1'b0;
        seed          = 32'h77d9;
        fetch_pc      = EXPECT_RESET_PC;
        errors        = 0;
        errs_at_start = 0;
        test_num      = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        cycles        = 0;
        repeat (3) exp_q.push_back(bubble(EXPECT_RESET_PC));

        // Reset is already high for the rising edge before the first step
        repeat (RESET_CYCLES - 1) step(NOP, fetch_pc, 32'd0, 32'd0, 1'b0);
        hold_reset = 1'b0;
        drain();
        end_test("after reset");

        run_random();
        drain();
        end_test("random ALU stream");

        issue(itype(OP_LUI, 32'h0002_abcd), 32'd0, 32'd0);
        issue(itype(OP_JAL, 32'h0000_0040), 32'd0, 32'd0);
        issue(itype(OP_ORI, 32'h0022_8001), 32'h1234_0000, 32'd0);
        drain();
        end_test("tnew countdown");

        issue(rtype(FN_ADDU, REGS_123), 32'd5, 32'd7);
        step(rtype(FN_XOR, REGS_123), fetch_pc, 32'hf0f0_0000, 32'h0ff0_0000, 1'b1);
        step(rtype(FN_XOR, REGS_123), fetch_pc, 32'hf0f0_0000, 32'h0ff0_0000, 1'b0);
        fetch_pc = fetch_pc + 32'd4;
        drain();
        end_test("hazard clear");

        issue(32'hfc00_0000, 32'd0, 32'd0);
        issue(rtype(FN_ADDU, REGS_123), 32'd1, 32'd2);
        issue(rtype(FN_ADD, REGS_123), 32'h7fff_ffff, 32'h0000_0001);
        issue(NOP, 32'd0, 32'd0);
        issue(rtype(6'h01, REGS_123), 32'd3, 32'd4);
        issue(NOP, 32'd0, 32'd0);
        issue(itype(OP_ADDI, 32'h0022_8000), 32'h8000_0000, 32'd0);
        drain();
        end_test("exceptions");

        epc = 32'h0000_3a5c;
        issue(ERET_WORD, 32'd0, 32'd0);
        issue(itype(OP_ADDIU, 32'h0022_0010), 32'd9, 32'd0);
        issue(itype(OP_ADDIU, 32'h0022_0020), 32'd9, 32'd0);
        drain();
        end_test("eret");

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- mips_de_ex_top.sv
`timescale 1ns/1ns

module mips_de_ex_top import mips_pkg::*; #(
    parameter word_t EXC_VECTOR = EXC_VECTOR_DEFAULT,
    parameter word_t RESET_PC   = RESET_PC_DEFAULT
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      clear,
    input  word_t     instr,
    input  word_t     pc,
    input  word_t     rs_data,
    input  word_t     rt_data,
    input  word_t     epc,
    output word_t     result_m,
    output word_t     pc_m,
    output word_t     pc_e,
    output reg_addr_t wreg_m,
    output reg_addr_t rs_e,
    output reg_addr_t rt_e,
    output logic      rfwe_m,
    output logic      exc,
    output tnew_t     tnew_e
);

    de_bus_if d_bus ();
    de_bus_if e_bus ();

    instr_decoder u_decoder (
        .instr   (instr),
        .pc      (pc),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .d_bus   (d_bus.producer)
    );

    de_pipe_reg #(
        .EXC_VECTOR (EXC_VECTOR),
        .RESET_PC   (RESET_PC)
    ) u_de_reg (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .exc_jump (exc),
        .epc      (epc),
        .d_bus    (d_bus.consumer),
        .e_bus    (e_bus.producer)
    );

    exec_stage u_exec (
        .clk      (clk),
        .reset    (reset),
        .e_bus    (e_bus.consumer),
        .exc_jump (exc),
        .result_m (result_m),
        .wreg_m   (wreg_m),
        .rfwe_m   (rfwe_m),
        .pc_m     (pc_m)
    );

    // E-stage view for the external hazard unit
    assign pc_e   = e_bus.pc;
    assign rs_e   = e_bus.rs;
    assign rt_e   = e_bus.rt;
    assign tnew_e = e_bus.tnew;

endmodule

//--- exec_stage.sv
`timescale 1ns/1ns

module exec_stage import mips_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    de_bus_if.consumer        e_bus,
    output logic              exc_jump,
    output word_t             result_m,
    output reg_addr_t         wreg_m,
    output logic              rfwe_m,
    output word_t             pc_m
);

    word_t     opa;
    word_t     opb;
    word_t     sum;
    word_t     diff;
    word_t     alu_out;
    word_t     result;
    reg_addr_t wreg;
    logic      ovf;

    assign opa  = e_bus.rs_data;
    assign sum  = opa + opb;
    assign diff = opa - opb;

    always_comb begin
        case (e_bus.bsel)
            BSEL_IMM:   opb = e_bus.ext_imm;
            BSEL_SHAMT: opb = {27'd0, e_bus.instr[10:6]};
            default:    opb = e_bus.rt_data;
        endcase
    end

    // Shifts move rt by the amount carried on B
    always_comb begin
        case (e_bus.alu_op)
            ALU_SUB:  alu_out = diff;
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SLT:  alu_out = {31'd0, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_out = {31'd0, opa < opb};
            ALU_SLL:  alu_out = e_bus.rt_data << opb[4:0];
            ALU_SRL:  alu_out = e_bus.rt_data >> opb[4:0];
            ALU_LUI:  alu_out = {opb[15:0], 16'h0000};
            ALU_PASSB: alu_out = opb;
            default:  alu_out = sum;
        endcase
    end

    always_comb begin
        case (e_bus.alu_op)
            ALU_ADD: ovf = (opa[31] == opb[31]) && (sum[31] != opa[31]);
            ALU_SUB: ovf = (opa[31] != opb[31]) && (diff[31] != opa[31]);
            default: ovf = 1'b0;
        endcase
    end

    assign exc_jump = e_bus.unknown | (e_bus.ovf_trap & ovf);

    always_comb begin
        case (e_bus.wreg_sel)
            WREG_RT:  wreg = e_bus.rt;
            WREG_R31: wreg = 5'd31;
            default:  wreg = e_bus.rd;
        endcase
    end

    assign result = (e_bus.wreg_sel == WREG_R31) ? e_bus.pc8 : alu_out;    // Link value for jal

    always_ff @(posedge clk) begin
        if (reset) begin
            rfwe_m <= 1'b0;
        end else begin
            rfwe_m <= e_bus.rfwe & ~exc_jump;    // A faulting instruction never writes back
        end
    end

    always_ff @(posedge clk) begin
        result_m <= result;
        wreg_m   <= wreg;
        pc_m     <= e_bus.pc;
    end

endmodule

//--- de_pipe_reg.sv
`timescale 1ns/1ns

module de_pipe_reg import mips_pkg::*; #(
    parameter word_t EXC_VECTOR = EXC_VECTOR_DEFAULT,
    parameter word_t RESET_PC   = RESET_PC_DEFAULT
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear,
    input  logic              exc_jump,
    input  word_t             epc,
    de_bus_if.consumer        d_bus,
    de_bus_if.producer        e_bus
);

    logic  flush;
    word_t pc_next;

    // The four bubble causes differ only in which pc the bubble carries
    always_comb begin
        flush   = 1'b1;
        pc_next = d_bus.pc;
        if (reset) begin
            pc_next = RESET_PC;
        end else if (clear) begin
            pc_next = d_bus.pc;    // Stall keeps the stalled pc visible in E
        end else if (exc_jump) begin
            pc_next = EXC_VECTOR;
        end else if (e_bus.is_eret) begin
            pc_next = epc;
        end else begin
            flush = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        e_bus.pc <= pc_next;
        if (flush) begin
            e_bus.rfwe     <= 1'b0;
            e_bus.ovf_trap <= 1'b0;
            e_bus.unknown  <= 1'b0;
            e_bus.is_eret  <= 1'b0;
            e_bus.alu_op   <= ALU_ADD;
            e_bus.bsel     <= BSEL_REG;
            e_bus.wreg_sel <= WREG_RD;
            e_bus.tnew     <= '0;
            e_bus.rs       <= '0;
            e_bus.rt       <= '0;
            e_bus.rd       <= '0;
            e_bus.rs_data  <= '0;
            e_bus.rt_data  <= '0;
            e_bus.ext_imm  <= '0;
            e_bus.instr    <= '0;
            e_bus.pc8      <= '0;
        end else begin
            e_bus.rfwe     <= d_bus.rfwe;
            e_bus.ovf_trap <= d_bus.ovf_trap;
            e_bus.unknown  <= d_bus.unknown;
            e_bus.is_eret  <= d_bus.is_eret;
            e_bus.alu_op   <= d_bus.alu_op;
            e_bus.bsel     <= d_bus.bsel;
            e_bus.wreg_sel <= d_bus.wreg_sel;
            e_bus.tnew     <= (d_bus.tnew != '0) ? d_bus.tnew - tnew_t'(1) : '0;
            e_bus.rs       <= d_bus.rs;
            e_bus.rt       <= d_bus.rt;
            e_bus.rd       <= d_bus.rd;
            e_bus.rs_data  <= d_bus.rs_data;
            e_bus.rt_data  <= d_bus.rt_data;
            e_bus.ext_imm  <= d_bus.ext_imm;
            e_bus.instr    <= d_bus.instr;
            e_bus.pc8      <= d_bus.pc8;
        end
    end

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import mips_pkg::*; (
    input  word_t             instr,
    input  word_t             pc,
    input  word_t             rs_data,
    input  word_t             rt_data,
    de_bus_if.producer        d_bus
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       is_eret;
    logic       rfwe;
    logic       ovf_trap;
    logic       unknown;
    logic       sign_ext;
    alu_op_t    alu_op;
    opnd_sel_t  bsel;
    wreg_sel_t  wreg_sel;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign is_eret = (instr == INSTR_ERET);

    always_comb begin
        rfwe     = 1'b0;
        ovf_trap = 1'b0;
        unknown  = 1'b0;
        sign_ext = 1'b1;
        alu_op   = ALU_ADD;
        bsel     = BSEL_REG;
        wreg_sel = WREG_RD;
        case (opcode)
            OP_RTYPE: begin
                rfwe = 1'b1;
                case (funct)
                    FN_ADD:  ovf_trap = 1'b1;
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB: begin
                        alu_op   = ALU_SUB;
                        ovf_trap = 1'b1;
                    end
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL: begin
                        alu_op = ALU_SLL;
                        bsel   = BSEL_SHAMT;
                    end
                    FN_SRL: begin
                        alu_op = ALU_SRL;
                        bsel   = BSEL_SHAMT;
                    end
                    default: begin
                        rfwe    = 1'b0;
                        unknown = 1'b1;
                    end
                endcase
            end
            OP_ADDI: begin
                rfwe     = 1'b1;
                ovf_trap = 1'b1;
                bsel     = BSEL_IMM;
                wreg_sel = WREG_RT;
            end
            OP_ADDIU, OP_SLTI: begin
                rfwe     = 1'b1;
                alu_op   = (opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
                bsel     = BSEL_IMM;
                wreg_sel = WREG_RT;
            end
            OP_ANDI, OP_ORI, OP_LUI: begin
                rfwe     = 1'b1;
                sign_ext = 1'b0;    // Logical immediates are zero-extended
                bsel     = BSEL_IMM;
                wreg_sel = WREG_RT;
                case (opcode)
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    default: alu_op = ALU_LUI;
                endcase
            end
            OP_JAL: begin
                rfwe     = 1'b1;
                alu_op   = ALU_PASSB;
                wreg_sel = WREG_R31;
            end
            default: unknown = ~is_eret;    // Eret has its own path through E
        endcase
    end

    assign d_bus.rfwe     = rfwe;
    assign d_bus.ovf_trap = ovf_trap;
    assign d_bus.unknown  = unknown;
    assign d_bus.is_eret  = is_eret;
    assign d_bus.alu_op   = alu_op;
    assign d_bus.bsel     = bsel;
    assign d_bus.wreg_sel = wreg_sel;
    assign d_bus.tnew     = rfwe ? tnew_t'(1) : tnew_t'(0);
    assign d_bus.rs       = instr[25:21];
    assign d_bus.rt       = instr[20:16];
    assign d_bus.rd       = instr[15:11];
    assign d_bus.rs_data  = rs_data;
    assign d_bus.rt_data  = rt_data;
    assign d_bus.ext_imm  = sign_ext ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};
    assign d_bus.instr    = instr;
    assign d_bus.pc       = pc;
    assign d_bus.pc8      = pc + 32'd8;

endmodule

//--- de_bus_if.sv
`timescale 1ns/1ns

interface de_bus_if import mips_pkg::*; ();

    logic      rfwe;
    logic      ovf_trap;     // Trap when the signed add or sub overflows
    logic      unknown;
    logic      is_eret;
    alu_op_t   alu_op;
    opnd_sel_t bsel;
    wreg_sel_t wreg_sel;
    tnew_t     tnew;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     rs_data;
    word_t     rt_data;
    word_t     ext_imm;
    word_t     instr;
    word_t     pc;
    word_t     pc8;

    modport producer (
        output rfwe, ovf_trap, unknown, is_eret, alu_op, bsel, wreg_sel, tnew,
        output rs, rt, rd, rs_data, rt_data, ext_imm, instr, pc, pc8
    );

    modport consumer (
        input rfwe, ovf_trap, unknown, is_eret, alu_op, bsel, wreg_sel, tnew,
        input rs, rt, rd, rs_data, rt_data, ext_imm, instr, pc, pc8
    );

endinterface

//--- mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  tnew_t;      // Stages until the result exists

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_PASSB
    } alu_op_t;

    typedef enum logic [1:0] {
        BSEL_REG,
        BSEL_IMM,
        BSEL_SHAMT
    } opnd_sel_t;

    typedef enum logic [1:0] {
        WREG_RD,
        WREG_RT,
        WREG_R31
    } wreg_sel_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam word_t INSTR_ERET = 32'h4200_0018;

    localparam word_t EXC_VECTOR_DEFAULT = 32'h0000_4180;
    localparam word_t RESET_PC_DEFAULT   = 32'h0000_3000;

endpackage
